//--- sources.f
+incdir+.
noc_pkg.sv
flit_fifo.sv
route_stage.sv
switch_alloc.sv
noc_router.sv
noc_router_checker.sv
tb_clock_gen.sv
tb_noc_router.sv

//--- tb_noc_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module tb_noc_router
    import noc_pkg::*;
();

    localparam int cur_x       = 2;
    localparam int cur_y       = 5;
    localparam int n_pairs     = 12;
    localparam int max_flits   = 512;
    localparam int drain_limit = 2000;

    logic  clk;
    logic  arst_n;
    flit_t in_xpos;
    flit_t in_ypos;
    flit_t inject_xpos;
    flit_t inject_ypos;
    flit_t out_xpos;
    flit_t out_ypos;
    flit_t eject_xpos;
    flit_t eject_ypos;

    ////////////////////
    // reference model
    ////////////////////
    // pair = source * 4 + destination
    // source 0 xpos, 1 ypos, 2 inject
    // destination 0 out_xpos, 1 out_ypos, 2 eject_xpos, 3 eject_ypos
    flit_t                     exp_mem [n_pairs][max_flits];
    int                        sent_cnt [n_pairs];
    int                        recv_cnt [n_pairs];
    logic [`NOC_PAYLOAD_W-3:0] seq_num [3];
    flit_t                     last_inj [2];
    int                        errors;

    tb_clock_gen u_clk (.clk(clk), .arst_n(arst_n));

    noc_router #(.CUR_X(cur_x), .CUR_Y(cur_y)) u_dut (
        .clk(clk), .arst_n(arst_n),
        .in_xpos(in_xpos), .in_ypos(in_ypos),
        .inject_xpos(inject_xpos), .inject_ypos(inject_ypos),
        .out_xpos(out_xpos), .out_ypos(out_ypos),
        .eject_xpos(eject_xpos), .eject_ypos(eject_ypos)
    );

    function automatic string port_name(input int d);
        case (d)
            0:       return "out_xpos";
            1:       return "out_ypos";
            2:       return "eject_xpos";
            default: return "eject_ypos";
        endcase
    endfunction

    // x first, then y, else eject where it came in
    function automatic int expected_port(input int src, input logic [2:0] x,
                                         input logic [2:0] y);
        if (x != 3'(cur_x)) begin
            return 0;
        end
        if (y != 3'(cur_y)) begin
            return 1;
        end
        return 2 + src;
    endfunction

    function automatic int total_sent();
        int s;
        s = 0;
        for (int p = 0; p < n_pairs; p++) begin
            s += sent_cnt[p];
        end
        return s;
    endfunction

    function automatic int total_recv();
        int s;
        s = 0;
        for (int p = 0; p < n_pairs; p++) begin
            s += recv_cnt[p];
        end
        return s;
    endfunction

    function automatic bit all_delivered();
        for (int p = 0; p < n_pairs; p++) begin
            if (recv_cnt[p] != sent_cnt[p]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // build a tagged flit and queue it as expected
    task automatic record_flit(input int src, input logic [2:0] x, input logic [2:0] y,
                               input int dst, output flit_t f);
        int pair;
        pair      = src * 4 + dst;
        f.valid   = 1'b1;
        f.dst_x   = x;
        f.dst_y   = y;
        f.payload = {2'(src), seq_num[src]};
        seq_num[src]++;
        exp_mem[pair][sent_cnt[pair]] = f;
        sent_cnt[pair]++;
    endtask

    // mode 0 eject only, 1 mixed, 2 inject only, 3 contention on xpos
    task automatic make_input(input int src, input int mode, output flit_t f);
        logic [2:0] x;
        logic [2:0] y;
        case (mode)
            0: begin
                x = 3'(cur_x);
                y = 3'(cur_y);
            end
            3: begin
                x = 3'($urandom % 8);
                if (x == 3'(cur_x)) begin
                    x = 3'd6;
                end
                y = 3'($urandom % 8);
            end
            default: begin
                // lean on the local column so ypos and eject get traffic
                x = ($urandom % 2 == 0) ? 3'(cur_x) : 3'($urandom % 8);
                y = ($urandom % 4 == 0) ? 3'(cur_y) : 3'($urandom % 8);
            end
        endcase
        record_flit(src, x, y, expected_port(src, x, y), f);
    endtask

    task automatic make_inject(input int o, output flit_t f);
        record_flit(2, 3'($urandom % 8), 3'($urandom % 8), o, f);
    endtask

    // match one observed flit against its pair queue
    task automatic score(input int d, input flit_t f);
        int src;
        int pair;
        if (f.valid === 1'b1) begin
            src = int'(f.payload[`NOC_PAYLOAD_W-1 -: 2]);
            pair = src * 4 + d;
            if (src > 2 || recv_cnt[pair] >= sent_cnt[pair]) begin
                $display("unexpected flit %h on %s at %0t", f, port_name(d), $time);
                errors++;
            end else begin
                if (f !== exp_mem[pair][recv_cnt[pair]]) begin
                    $display("FAIL %0t %s expected %h got %h", $time, port_name(d),
                             exp_mem[pair][recv_cnt[pair]], f);
                    errors++;
                end
                recv_cnt[pair]++;
            end
        end
    endtask

    ////////////////////
    // output monitor
    ////////////////////
    // falling edge, outputs settled since the rising edge
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            score(0, out_xpos);
            score(1, out_ypos);
            score(2, eject_xpos);
            score(3, eject_ypos);
            // inject goes straight through one register
            if (last_inj[0].valid === 1'b1 && out_xpos !== last_inj[0]) begin
                $display("FAIL %0t out_xpos expected %h got %h", $time, last_inj[0], out_xpos);
                errors++;
            end
            if (last_inj[1].valid === 1'b1 && out_ypos !== last_inj[1]) begin
                $display("FAIL %0t out_ypos expected %h got %h", $time, last_inj[1], out_ypos);
                errors++;
            end
        end
        last_inj[0] = inject_xpos;
        last_inj[1] = inject_ypos;
    end

    task automatic wait_reset();
        int n;
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end
    endtask

    // all valids low with nothing driven
    task automatic check_idle();
        logic [3:0] v;
        int         err_start;
        err_start = errors;
        repeat (4) begin
            @(negedge clk);
            v = {eject_ypos.valid, eject_xpos.valid, out_ypos.valid, out_xpos.valid};
            for (int d = 0; d < 4; d++) begin
                if (v[d] !== 1'b0) begin
                    $display("FAIL %0t %s.valid expected 0 got %b", $time, port_name(d), v[d]);
                    errors++;
                end
            end
        end
        $display("test reset finished: %0d errors", errors - err_start);
    endtask

    task automatic drain(output bit ok);
        int n;
        n = 0;
        while (!all_delivered() && n < drain_limit) begin
            @(posedge clk);
            n++;
        end
        ok = all_delivered();
        // a short gap so late duplicates still land in this test
        repeat (4) @(posedge clk);
    endtask

    task automatic run_phase(input string name, input int mode, input int cycles);
        int    err_start;
        int    sent_start;
        int    gap_x;
        int    gap_y;
        bit    ok;
        flit_t fx;
        flit_t fy;
        flit_t ix;
        flit_t iy;
        err_start  = errors;
        sent_start = total_sent();
        gap_x      = 4;
        gap_y      = 4;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            fx = '0;
            fy = '0;
            ix = '0;
            iy = '0;
            gap_x++;
            gap_y++;
            // each input at most every fourth cycle
            if (mode != 2 && gap_x >= 4 && (mode == 3 || $urandom % 2 == 0)) begin
                make_input(0, mode, fx);
                gap_x = 0;
            end
            if (mode != 2 && gap_y >= 4 && (mode == 3 || $urandom % 2 == 0)) begin
                make_input(1, mode, fy);
                gap_y = 0;
            end
            if ((mode == 1 && $urandom % 16 == 0) || (mode == 2 && $urandom % 2 == 0) ||
                (mode == 3 && $urandom % 8 == 0)) begin
                make_inject(0, ix);
            end
            if ((mode == 1 && $urandom % 16 == 0) || (mode == 2 && $urandom % 2 == 0) ||
                (mode == 3 && $urandom % 8 == 0)) begin
                make_inject(1, iy);
            end
            in_xpos     <= fx;
            in_ypos     <= fy;
            inject_xpos <= ix;
            inject_ypos <= iy;
        end
        @(posedge clk);
        in_xpos     <= '0;
        in_ypos     <= '0;
        inject_xpos <= '0;
        inject_ypos <= '0;
        drain(ok);
        if (!ok) begin
            $display("test %s: flits still missing after %0d cycles", name, drain_limit);
            errors++;
        end
        $display("test %s finished: %0d flits, %0d errors", name,
                 total_sent() - sent_start, errors - err_start);
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial begin
        in_xpos     = '0;
        in_ypos     = '0;
        inject_xpos = '0;
        inject_ypos = '0;
        errors      = 0;
        for (int p = 0; p < n_pairs; p++) begin
            sent_cnt[p] = 0;
            recv_cnt[p] = 0;
        end
        for (int s = 0; s < 3; s++) begin
            seq_num[s] = '0;
        end
        void'($urandom(32'h34fc));
        wait_reset();
        check_idle();
        run_phase("eject", 0, 80);
        run_phase("mixed", 1, 400);
        run_phase("inject", 2, 100);
        run_phase("contention", 3, 400);
        // every pair must balance
        for (int p = 0; p < n_pairs; p++) begin
            if (recv_cnt[p] != sent_cnt[p]) begin
                $display("source %0d to %s: %0d sent, %0d delivered", p / 4,
                         port_name(p % 4), sent_cnt[p], recv_cnt[p]);
                errors++;
            end
        end
        $display("flits sent %0d, delivered %0d, errors %0d", total_sent(), total_recv(),
                 errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for three rising edges, released on an edge
    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- noc_router_checker.sv
`timescale 1ns/1ns
`default_nettype none

module noc_router_checker (
    input wire clk,
    input wire arst_n,
    input wire push,
    input wire pop,
    input wire empty,
    input wire full
);

    ////////////////////
    // queue handshake
    ////////////////////

    // upstream must hold off while full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) full |-> !push
    ) else $error("queue pushed while full");

    // downstream only pops a real entry
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) empty |-> !pop
    ) else $error("queue popped while empty");

    // a pushed entry sits at the head one cycle later
    a_push_not_empty: assert property (
        @(posedge clk) disable iff (!arst_n) push |=> !empty
    ) else $error("queue still empty after a push");

endmodule

// every input and switch queue in the router
bind flit_fifo noc_router_checker u_checker (
    .clk(clk), .arst_n(arst_n), .push(push), .pop(pop),
    .empty(empty), .full(full)
);

`default_nettype wire

//--- noc_router.sv
`timescale 1ns/1ns
`default_nettype none

module noc_router
    import noc_pkg::*;
#(
    parameter int CUR_X = 0,
    parameter int CUR_Y = 0
) (
    input  wire   clk,
    input  wire   arst_n,
    input  flit_t in_xpos,
    input  flit_t in_ypos,
    input  flit_t inject_xpos,
    input  flit_t inject_ypos,
    output flit_t out_xpos,
    output flit_t out_ypos,
    output flit_t eject_xpos,
    output flit_t eject_ypos
);

    // input queue to route stage
    flit_t        in_head_xpos;
    flit_t        in_head_ypos;
    logic         in_empty_xpos;
    logic         in_empty_ypos;
    logic         in_pop_xpos;
    logic         in_pop_ypos;

    // route stage to switch queue
    routed_flit_t fwd_xpos;
    routed_flit_t fwd_ypos;
    logic         fwd_push_xpos;
    logic         fwd_push_ypos;
    logic         sw_full_xpos;
    logic         sw_full_ypos;

    // switch queue to allocator
    routed_flit_t sw_head_xpos;
    routed_flit_t sw_head_ypos;
    logic         sw_empty_xpos;
    logic         sw_empty_ypos;
    logic         grant_xpos;
    logic         grant_ypos;

    ////////////////////
    // input queues
    ////////////////////
    // no ready upstream, the link rate must keep these from filling
    flit_fifo #(.data_t(flit_t)) u_in_q_xpos (
        .clk(clk), .arst_n(arst_n),
        .push(in_xpos.valid), .push_data(in_xpos), .pop(in_pop_xpos),
        .head(in_head_xpos), .empty(in_empty_xpos), .full()
    );

    flit_fifo #(.data_t(flit_t)) u_in_q_ypos (
        .clk(clk), .arst_n(arst_n),
        .push(in_ypos.valid), .push_data(in_ypos), .pop(in_pop_ypos),
        .head(in_head_ypos), .empty(in_empty_ypos), .full()
    );

    ////////////////////
    // route computation
    ////////////////////
    route_stage #(.CUR_X(CUR_X), .CUR_Y(CUR_Y)) u_route_xpos (
        .clk(clk), .arst_n(arst_n),
        .q_head(in_head_xpos), .q_empty(in_empty_xpos), .q_pop(in_pop_xpos),
        .eject(eject_xpos), .fwd(fwd_xpos), .fwd_push(fwd_push_xpos),
        .fwd_full(sw_full_xpos)
    );

    route_stage #(.CUR_X(CUR_X), .CUR_Y(CUR_Y)) u_route_ypos (
        .clk(clk), .arst_n(arst_n),
        .q_head(in_head_ypos), .q_empty(in_empty_ypos), .q_pop(in_pop_ypos),
        .eject(eject_ypos), .fwd(fwd_ypos), .fwd_push(fwd_push_ypos),
        .fwd_full(sw_full_ypos)
    );

    ////////////////////
    // switch queues
    ////////////////////
    flit_fifo #(.data_t(routed_flit_t)) u_sw_q_xpos (
        .clk(clk), .arst_n(arst_n),
        .push(fwd_push_xpos), .push_data(fwd_xpos), .pop(grant_xpos),
        .head(sw_head_xpos), .empty(sw_empty_xpos), .full(sw_full_xpos)
    );

    flit_fifo #(.data_t(routed_flit_t)) u_sw_q_ypos (
        .clk(clk), .arst_n(arst_n),
        .push(fwd_push_ypos), .push_data(fwd_ypos), .pop(grant_ypos),
        .head(sw_head_ypos), .empty(sw_empty_ypos), .full(sw_full_ypos)
    );

    // allocator and output registers
    switch_alloc u_switch (
        .clk(clk), .arst_n(arst_n),
        .req_xpos(sw_head_xpos), .req_ypos(sw_head_ypos),
        .empty_xpos(sw_empty_xpos), .empty_ypos(sw_empty_ypos),
        .grant_xpos(grant_xpos), .grant_ypos(grant_ypos),
        .inject_xpos(inject_xpos), .inject_ypos(inject_ypos),
        .out_xpos(out_xpos), .out_ypos(out_ypos)
    );

endmodule

`default_nettype wire

//--- switch_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module switch_alloc
    import noc_pkg::*;
(
    input  wire          clk,
    input  wire          arst_n,
    input  routed_flit_t req_xpos,
    input  routed_flit_t req_ypos,
    input  wire          empty_xpos,
    input  wire          empty_ypos,
    output logic         grant_xpos,
    output logic         grant_ypos,
    input  flit_t        inject_xpos,
    input  flit_t        inject_ypos,
    output flit_t        out_xpos,
    output flit_t        out_ypos
);

    // index 0 is xpos, index 1 is ypos
    // for inputs and outputs alike
    routed_flit_t req [2];
    flit_t        inj [2];
    logic [1:0]   req_ok;
    logic [1:0]   cand [2];

    // per output arbitration state
    logic [1:0]   rr_ptr;
    logic [1:0]   win_sw;
    logic [1:0]   win_src;
    logic [1:0]   grant;
    flit_t        nxt [2];

    // output registers
    flit_t        out_data [2];
    logic [1:0]   out_vld;

    assign req[0]    = req_xpos;
    assign req[1]    = req_ypos;
    assign req_ok[0] = !empty_xpos;
    assign req_ok[1] = !empty_ypos;
    assign inj[0]    = inject_xpos;
    assign inj[1]    = inject_ypos;

    ////////////////////
    // arbitration
    ////////////////////
    always_comb begin
        grant = '0;
        for (int o = 0; o < 2; o++) begin
            // queue heads routed to this output
            cand[o][0] = req_ok[0] && (req[0].port == out_port_e'(o));
            cand[o][1] = req_ok[1] && (req[1].port == out_port_e'(o));
            // local inject beats the switch queues
            win_sw[o] = !inj[o].valid && (|cand[o]);
            if (cand[o] == 2'b11) begin
                win_src[o] = rr_ptr[o];
            end else begin
                win_src[o] = cand[o][1];
            end
            // crossbar
            if (inj[o].valid) begin
                nxt[o] = inj[o];
            end else begin
                nxt[o]       = req[win_src[o]].flit;
                nxt[o].valid = win_sw[o];
            end
            if (win_sw[o]) begin
                grant[win_src[o]] = 1'b1;
            end
        end
    end

    // pop strobes back to the switch queues
    assign grant_xpos = grant[0];
    assign grant_ypos = grant[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr  <= '0;
            out_vld <= '0;
        end else begin
            for (int o = 0; o < 2; o++) begin
                out_vld[o] <= nxt[o].valid;
                // next time favour the other input
                if (win_sw[o]) begin
                    rr_ptr[o] <= !win_src[o];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < 2; o++) begin
            out_data[o] <= nxt[o];
        end
    end

    ////////////////////
    // network outputs
    ////////////////////
    always_comb begin
        out_xpos       = out_data[0];
        out_xpos.valid = out_vld[0];
        out_ypos       = out_data[1];
        out_ypos.valid = out_vld[1];
    end

endmodule

`default_nettype wire

//--- route_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module route_stage
    import noc_pkg::*;
#(
    parameter int CUR_X = 0,
    parameter int CUR_Y = 0
) (
    input  wire          clk,
    input  wire          arst_n,
    input  flit_t        q_head,
    input  wire          q_empty,
    output logic         q_pop,
    output flit_t        eject,
    output routed_flit_t fwd,
    output logic         fwd_push,
    input  wire          fwd_full
);

    // this node, trimmed to coordinate width
    localparam logic [`NOC_COORD_W-1:0] cur_x_c = CUR_X[`NOC_COORD_W-1:0];
    localparam logic [`NOC_COORD_W-1:0] cur_y_c = CUR_Y[`NOC_COORD_W-1:0];

    routed_flit_t hold;
    routed_flit_t nxt;
    logic         hold_vld;
    logic         hold_eject;
    logic         at_x;
    logic         at_y;
    logic         drain;

    ////////////////////
    // route computation
    ////////////////////
    always_comb begin
        at_x     = (q_head.dst_x == cur_x_c);
        at_y     = (q_head.dst_y == cur_y_c);
        nxt.flit = q_head;
        // x first, then y
        nxt.port = at_x ? port_ypos : port_xpos;
    end

    // eject always drains, forward only with room downstream
    assign drain = hold_vld && (hold_eject || !fwd_full);
    assign q_pop = !q_empty && (!hold_vld || drain);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_vld   <= 1'b0;
            hold_eject <= 1'b0;
        end else if (q_pop) begin
            hold_vld   <= 1'b1;
            hold_eject <= at_x && at_y;
        end else if (drain) begin
            hold_vld   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            hold <= nxt;
        end
    end

    ////////////////////
    // stage outputs
    ////////////////////
    always_comb begin
        eject          = hold.flit;
        eject.valid    = hold_vld && hold_eject;
        fwd            = hold;
        fwd.flit.valid = hold_vld && !hold_eject;
        // held here while the switch queue is full
        fwd_push       = hold_vld && !hold_eject && !fwd_full;
    end

endmodule

`default_nettype wire

//--- flit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_macros.svh"

module flit_fifo
    import noc_pkg::*;
#(
    parameter type data_t = flit_t,
    parameter int  depth  = `NOC_QUEUE_DEPTH
) (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   push,
    input  data_t push_data,
    input  wire   pop,
    output data_t head,
    output logic  empty,
    output logic  full
);

    // pointer and occupancy widths
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // storage, no reset needed
    data_t            mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // wrap at depth, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop keeps count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // fall-through head, poppable in the same cycle
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

endmodule

`default_nettype wire

//--- noc_pkg.sv
`default_nettype none

package noc_pkg;

`include "noc_macros.svh"

    ////////////////////
    // flit format
    ////////////////////

    // one network word
    // valid on top, destination next, payload at the bottom
    typedef struct packed {
        logic                      valid;
        logic [`NOC_COORD_W-1:0]   dst_x;
        logic [`NOC_COORD_W-1:0]   dst_y;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } flit_t;

    // network output chosen by route computation
    typedef enum logic {
        port_xpos = 1'b0,
        port_ypos = 1'b1
    } out_port_e;

    // flit plus its route, held in the switch queues
    typedef struct packed {
        flit_t     flit;
        out_port_e port;
    } routed_flit_t;

endpackage

`default_nettype wire

//--- noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

////////////////////
// mesh geometry
////////////////////

// bits per mesh coordinate
// 3 bits covers an 8 by 8 mesh
`define NOC_COORD_W 3

////////////////////
// flit and queues
////////////////////

// flit payload bits
`define NOC_PAYLOAD_W 16

// entries in every input and switch queue
`define NOC_QUEUE_DEPTH 4

`endif
